// ==== include/lsq_defines.svh ====
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// store queue entries, kept a power of two so the pointers wrap for free
`define SQ_DEPTH 8

// log2 of SQ_DEPTH
`define SQ_IDX_BITS 3

// byte address width on the command side
`define ADDR_WIDTH 16

// data RAM depth in 32-bit words
// word addresses wrap modulo this size
`define RAM_WORDS 64

`endif

// ==== design/mem_isa_pkg.sv ====
`include "lsq_defines.svh"

package mem_isa_pkg;

    // memory opcodes seen by the back end
    typedef enum logic [2:0] {
        OP_NOP,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_LW
    } mem_op_e;

    // one command per cycle, address and data already known
    typedef struct packed {
        mem_op_e                 op;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [31:0]             data;
    } mem_cmd_t;

    // decoded access with the store bytes already in their lanes
    typedef struct packed {
        logic                    is_store;
        logic                    is_load;
        logic [`ADDR_WIDTH-3:0]  word_addr;
        logic [3:0]              mask;
        logic [31:0]             data;
    } mem_access_t;

endpackage

// ==== design/lsq_pkg.sv ====
`include "lsq_defines.svh"

package lsq_pkg;

    // wrap bit on top tells a full queue from an empty one
    typedef struct packed {
        logic                     wrap;
        logic [`SQ_IDX_BITS-1:0]  idx;
    } sq_ptr_t;

    // one queued store
    typedef struct packed {
        logic [`ADDR_WIDTH-3:0]  word_addr;
        logic [3:0]              mask;
        logic [31:0]             data;
    } sq_entry_t;

    // drain write towards the data RAM
    typedef struct packed {
        logic                    valid;
        logic [`ADDR_WIDTH-3:0]  word_addr;
        logic [3:0]              mask;
        logic [31:0]             data;
    } store_write_t;

    // bytes found in the queue for a load, one mask bit per lane
    typedef struct packed {
        logic [3:0][7:0]  data;
        logic [3:0]       mask;
    } fwd_result_t;

endpackage

// ==== design/mem_op_decode.sv ====
`include "lsq_defines.svh"

module mem_op_decode (
    input  mem_isa_pkg::mem_cmd_t     cmd,
    output mem_isa_pkg::mem_access_t  access
);

    always_comb begin
        access = '0;
        access.word_addr = cmd.addr[`ADDR_WIDTH-1:2];

        case (cmd.op)
            mem_isa_pkg::OP_SB: begin
                access.is_store = 1'b1;
                access.mask     = 4'b0001 << cmd.addr[1:0];
                access.data     = {24'b0, cmd.data[7:0]} << {cmd.addr[1:0], 3'b000};
            end
            mem_isa_pkg::OP_SH: begin
                // addr[0] is ignored, halfwords sit on lanes 0-1 or 2-3
                access.is_store = 1'b1;
                access.mask     = cmd.addr[1] ? 4'b1100 : 4'b0011;
                access.data     = {16'b0, cmd.data[15:0]} << {cmd.addr[1], 4'b0000};
            end
            mem_isa_pkg::OP_SW: begin
                access.is_store = 1'b1;
                access.mask     = 4'b1111;
                access.data     = cmd.data;
            end
            mem_isa_pkg::OP_LW: begin
                access.is_load = 1'b1;
                access.mask    = 4'b1111;
            end
            default: begin
                // nop, flags stay low
                access.is_store = 1'b0;
                access.is_load  = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/store_queue.sv ====
`include "lsq_defines.svh"

module store_queue (
    input  logic                         clock,
    input  logic                         reset,
    input  mem_isa_pkg::mem_access_t     access,
    input  logic                         retire,
    input  logic                         squash,
    input  logic                         drain_hold,
    input  logic                         ram_busy,
    output lsq_pkg::store_write_t        store_write,
    output lsq_pkg::fwd_result_t         fwd,
    output logic [`SQ_IDX_BITS:0]        count,
    output logic                         full
);

    localparam int IDX    = `SQ_IDX_BITS;
    localparam int DEPTH  = `SQ_DEPTH;
    localparam int RAM_AW = $clog2(`RAM_WORDS);

    lsq_pkg::sq_entry_t entries [DEPTH];

    // head: oldest not drained, ret: oldest not retired, tail: next free
    lsq_pkg::sq_ptr_t head_q;
    lsq_pkg::sq_ptr_t ret_q;
    lsq_pkg::sq_ptr_t tail_q;

    logic [IDX:0]     retired_count;
    logic             enq;
    logic             drain;
    logic [DEPTH-1:0] live;

    assign count         = tail_q - head_q;
    assign full          = (count == (IDX+1)'(DEPTH));
    assign retired_count = ret_q - head_q;

    assign enq   = access.is_store && !full;
    // RAM sweep after reset holds the drain the same way drain_hold does
    assign drain = (retired_count != '0) && !drain_hold && !ram_busy;

    assign store_write.valid     = drain;
    assign store_write.word_addr = entries[head_q.idx].word_addr;
    assign store_write.mask      = entries[head_q.idx].mask;
    assign store_write.data      = entries[head_q.idx].data;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            ret_q  <= '0;
            tail_q <= '0;
        end else begin
            if (drain) begin
                head_q <= lsq_pkg::sq_ptr_t'(head_q + 1'b1);
            end
            if (retire) begin
                ret_q <= lsq_pkg::sq_ptr_t'(ret_q + 1'b1);
            end
            // squash drops everything younger than the retire pointer
            if (squash) begin
                tail_q <= ret_q;
            end else if (enq) begin
                tail_q <= lsq_pkg::sq_ptr_t'(tail_q + 1'b1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            entries[tail_q.idx].word_addr <= access.word_addr;
            entries[tail_q.idx].mask      <= access.mask;
            entries[tail_q.idx].data      <= access.data;
        end
    end

    // a slot is live when its distance from head is below count
    always_comb begin
        logic [IDX-1:0] off;
        off  = '0;
        live = '0;
        for (int j = 0; j < DEPTH; j++) begin
            off     = IDX'(j) - head_q.idx;
            live[j] = ({1'b0, off} < count);
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [DEPTH-1:0]   hit;
        logic [DEPTH-1:0]   hit_age;
        logic [2*DEPTH-1:0] hit_dbl;
        logic [IDX-1:0]     pick;
        logic               found;

        always_comb begin
            for (int j = 0; j < DEPTH; j++) begin
                hit[j] = live[j] && entries[j].mask[i] &&
                         (entries[j].word_addr[RAM_AW-1:0] == access.word_addr[RAM_AW-1:0]);
            end

            // rotate so bit 0 is the slot at the tail, oldest first
            hit_dbl = {hit, hit} >> tail_q.idx;
            hit_age = hit_dbl[DEPTH-1:0];

            // last hit in age order is the youngest older store
            found = 1'b0;
            pick  = '0;
            for (int k = 0; k < DEPTH; k++) begin
                if (hit_age[k]) begin
                    found = 1'b1;
                    pick  = tail_q.idx + IDX'(k);
                end
            end
        end

        assign fwd.data[i] = entries[pick].data[8*i +: 8];
        assign fwd.mask[i] = found;
    end

    a_no_enq_full: assert property (
        @(posedge clock) disable iff (reset) access.is_store |-> !full
    );

    a_no_retire_past_tail: assert property (
        @(posedge clock) disable iff (reset) retire |-> (ret_q != tail_q)
    );

    // drained stores are always retired ones, so head stays behind ret
    a_head_behind_retire: assert property (
        @(posedge clock) disable iff (reset) drain |=> (retired_count <= count)
    );

endmodule

// ==== design/data_ram.sv ====
`include "lsq_defines.svh"

module data_ram (
    input  logic                        clock,
    input  logic                        reset,
    input  lsq_pkg::store_write_t       store_write,
    input  logic [`ADDR_WIDTH-3:0]      rd_addr,
    output logic [31:0]                 rd_data,
    output logic                        ram_busy
);

    localparam int RAM_AW = $clog2(`RAM_WORDS);

    logic [3:0][7:0] mem [`RAM_WORDS];

    logic [RAM_AW-1:0] sweep_q;
    logic              busy_q;

    assign ram_busy = busy_q;

    // zero sweep writes one word per cycle after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            sweep_q <= '0;
            busy_q  <= 1'b1;
        end else if (busy_q) begin
            sweep_q <= sweep_q + 1'b1;
            if (&sweep_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (busy_q) begin
            mem[sweep_q] <= '0;
        end else if (store_write.valid) begin
            for (int b = 0; b < 4; b++) begin
                if (store_write.mask[b]) begin
                    mem[store_write.word_addr[RAM_AW-1:0]][b] <= store_write.data[8*b +: 8];
                end
            end
        end
        rd_data <= mem[rd_addr[RAM_AW-1:0]];
    end

endmodule

// ==== design/load_result_merge.sv ====
module load_result_merge (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_isa_pkg::mem_access_t  access,
    input  lsq_pkg::fwd_result_t      fwd,
    input  logic [31:0]               rd_data,
    output logic                      load_valid,
    output logic [31:0]               load_data
);

    logic                 valid_q;
    lsq_pkg::fwd_result_t fwd_q;

    assign load_valid = valid_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= access.is_load;
        end
    end

    // forwarded bytes wait one cycle to line up with the RAM read
    always_ff @(posedge clock) begin
        fwd_q <= fwd;
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (fwd_q.mask[i]) begin
                load_data[8*i +: 8] = fwd_q.data[i];
            end else begin
                load_data[8*i +: 8] = rd_data[8*i +: 8];
            end
        end
    end

endmodule

// ==== design/mem_subsystem.sv ====
`include "lsq_defines.svh"

module mem_subsystem (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_isa_pkg::mem_cmd_t    cmd,
    input  logic                     retire,
    input  logic                     squash,
    input  logic                     drain_hold,
    output logic                     sq_full,
    output logic [`SQ_IDX_BITS:0]    sq_count,
    output logic                     load_valid,
    output logic [31:0]              load_data
);

    mem_isa_pkg::mem_access_t access;
    lsq_pkg::store_write_t    store_write;
    lsq_pkg::fwd_result_t     fwd;
    logic [31:0]              rd_data;
    logic                     ram_busy;

    mem_op_decode u_decode (
        .cmd    (cmd),
        .access (access)
    );

    store_queue u_sq (
        .clock       (clock),
        .reset       (reset),
        .access      (access),
        .retire      (retire),
        .squash      (squash),
        .drain_hold  (drain_hold),
        .ram_busy    (ram_busy),
        .store_write (store_write),
        .fwd         (fwd),
        .count       (sq_count),
        .full        (sq_full)
    );

    // loads read the RAM in the issue cycle, data returns next cycle
    data_ram u_ram (
        .clock       (clock),
        .reset       (reset),
        .store_write (store_write),
        .rd_addr     (access.word_addr),
        .rd_data     (rd_data),
        .ram_busy    (ram_busy)
    );

    load_result_merge u_merge (
        .clock      (clock),
        .reset      (reset),
        .access     (access),
        .fwd        (fwd),
        .rd_data    (rd_data),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

// ==== bench/mem_subsystem_tb.sv ====
`include "lsq_defines.svh"

module mem_subsystem_tb;

    localparam int NUM_CYCLES  = 2000;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int WORDS_USED  = 4;
    localparam int RAM_BYTES   = `RAM_WORDS * 4;
    localparam int RAM_BYTE_AW = $clog2(RAM_BYTES);

    logic                   clock;
    logic                   reset;
    mem_isa_pkg::mem_cmd_t  cmd;
    logic                   retire;
    logic                   squash;
    logic                   drain_hold;
    logic                   sq_full;
    logic [`SQ_IDX_BITS:0]  sq_count;
    logic                   load_valid;
    logic [31:0]            load_data;

    integer seed;

    // reference model queue with the oldest live store at the front
    // model_retired counts the retired stores at the front
    lsq_pkg::sq_entry_t model_q [$];
    int                 model_retired;
    logic [7:0]         model_ram [RAM_BYTES];

    // load issued last cycle and its expected word
    logic               pending_load;
    logic [31:0]        pending_word;
    int                 pending_addr;
    int                 loads_checked;
    int                 hold_left;

    mem_subsystem UUT (
        .clock      (clock),
        .reset      (reset),
        .cmd        (cmd),
        .retire     (retire),
        .squash     (squash),
        .drain_hold (drain_hold),
        .sq_full    (sq_full),
        .sq_count   (sq_count),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [RAM_BYTE_AW-1:0] ram_index(input logic [`ADDR_WIDTH-3:0] w,
                                                         input int lane);
        return RAM_BYTE_AW'((int'(w) % `RAM_WORDS) * 4 + lane);
    endfunction

    function automatic bit is_store_op(input mem_isa_pkg::mem_op_e op);
        return (op == mem_isa_pkg::OP_SB) || (op == mem_isa_pkg::OP_SH) ||
               (op == mem_isa_pkg::OP_SW);
    endfunction

    // byte lanes and bytes a store command writes
    function automatic lsq_pkg::sq_entry_t make_entry(input mem_isa_pkg::mem_cmd_t c);
        lsq_pkg::sq_entry_t e;
        bit                 sel;
        int                 k;
        e = '0;
        e.word_addr = c.addr[`ADDR_WIDTH-1:2];
        for (int b = 0; b < 4; b++) begin
            sel = 1'b0;
            k   = 0;
            case (c.op)
                mem_isa_pkg::OP_SB: begin
                    sel = (b == int'(c.addr[1:0]));
                    k   = 0;
                end
                mem_isa_pkg::OP_SH: begin
                    // low byte of the halfword lands on the even lane
                    sel = ((b / 2) == int'(c.addr[1]));
                    k   = b % 2;
                end
                mem_isa_pkg::OP_SW: begin
                    sel = 1'b1;
                    k   = b;
                end
                default: begin
                    sel = 1'b0;
                end
            endcase
            if (sel) begin
                e.mask[b]        = 1'b1;
                e.data[8*b +: 8] = c.data[8*k +: 8];
            end
        end
        return e;
    endfunction

    // the newest queued store covering a lane wins over the RAM byte
    function automatic logic [31:0] expected_load(input logic [`ADDR_WIDTH-3:0] word_addr);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model_ram[ram_index(word_addr, b)];
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].word_addr == word_addr && model_q[i].mask[b]) begin
                    w[8*b +: 8] = model_q[i].data[8*b +: 8];
                end
            end
        end
        return w;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH time %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "output differs from the reference model");
        end
    endtask

    // applies the inputs of the cycle that just ended
    task automatic update_model();
        lsq_pkg::sq_entry_t e;
        bit                 do_drain;
        do_drain = (model_retired > 0) && !drain_hold;
        if (do_drain) begin
            e = model_q.pop_front();
            for (int b = 0; b < 4; b++) begin
                if (e.mask[b]) begin
                    model_ram[ram_index(e.word_addr, b)] = e.data[8*b +: 8];
                end
            end
            model_retired--;
        end
        if (retire) begin
            model_retired++;
        end
        if (squash) begin
            while (model_q.size() > model_retired) begin
                void'(model_q.pop_back());
            end
        end else if (is_store_op(cmd.op)) begin
            model_q.push_back(make_entry(cmd));
        end
    endtask

    task automatic check_outputs();
        check_value(32'(sq_count), 32'(model_q.size()), "sq_count");
        check_value(32'(sq_full), 32'(model_q.size() == `SQ_DEPTH), "sq_full");
        check_value(32'(load_valid), 32'(pending_load), "load_valid");
        if (pending_load) begin
            check_value(load_data, pending_word, $sformatf("load_data word %0d", pending_addr));
            loads_checked++;
        end
    endtask

    task automatic random_inputs();
        int r;
        int spec;
        spec = model_q.size() - model_retired;

        // long hold stretches let retired stores pile up
        if (hold_left > 0) begin
            hold_left--;
        end else if (rand_below(40) == 0) begin
            hold_left = 20 + rand_below(40);
        end
        drain_hold = (hold_left > 0) || (rand_below(8) == 0);

        squash = (rand_below(24) == 0);
        retire = !squash && (spec > 0) && (rand_below(3) == 0);

        cmd      = '0;
        cmd.addr = 16'(rand_below(4 * WORDS_USED));
        cmd.data = $random(seed);
        r = rand_below(10);
        if (squash || r < 1) begin
            cmd.op = mem_isa_pkg::OP_NOP;
        end else if (r < 3) begin
            cmd.op = mem_isa_pkg::OP_SB;
        end else if (r < 5) begin
            cmd.op = mem_isa_pkg::OP_SH;
        end else if (r < 7) begin
            cmd.op = mem_isa_pkg::OP_SW;
        end else begin
            cmd.op = mem_isa_pkg::OP_LW;
        end
        // a full queue takes no store
        if (is_store_op(cmd.op) && model_q.size() == `SQ_DEPTH) begin
            cmd.op = mem_isa_pkg::OP_LW;
        end
    endtask

    // retires what is left with the hold off and may load one word
    task automatic flush_inputs(input bit do_load, input int word);
        cmd        = '0;
        squash     = 1'b0;
        drain_hold = 1'b0;
        retire     = (model_q.size() > model_retired);
        if (do_load) begin
            cmd.op   = mem_isa_pkg::OP_LW;
            cmd.addr = 16'(4 * word);
        end
    endtask

    task automatic run_cycle(input bit flush, input bit do_load, input int word);
        @(posedge clock);
        update_model();
        #DRIVE_DELAY;
        check_outputs();
        if (flush) begin
            flush_inputs(do_load, word);
        end else begin
            random_inputs();
        end
        if (cmd.op == mem_isa_pkg::OP_LW) begin
            pending_load = 1'b1;
            pending_addr = int'(cmd.addr[`ADDR_WIDTH-1:2]);
            pending_word = expected_load(cmd.addr[`ADDR_WIDTH-1:2]);
        end else begin
            pending_load = 1'b0;
        end
    endtask

    initial begin
        seed          = 32'h66b2;
        clock         = 1'b0;
        reset         = 1'b1;
        cmd           = '0;
        retire        = 1'b0;
        squash        = 1'b0;
        drain_hold    = 1'b0;
        pending_load  = 1'b0;
        pending_word  = '0;
        pending_addr  = 0;
        model_retired = 0;
        loads_checked = 0;
        hold_left     = 0;
        for (int i = 0; i < RAM_BYTES; i++) begin
            model_ram[RAM_BYTE_AW'(i)] = 8'h00;
        end

        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_outputs();

        // the RAM clears one word per cycle after reset
        repeat (`RAM_WORDS) @(posedge clock);
        #DRIVE_DELAY;
        check_outputs();

        for (int n = 0; n < NUM_CYCLES; n++) begin
            run_cycle(1'b0, 1'b0, 0);
        end

        // everything left retires and drains before RAM alone answers the loads
        while (model_q.size() != 0) begin
            run_cycle(1'b1, 1'b0, 0);
        end
        for (int w = 0; w < WORDS_USED; w++) begin
            run_cycle(1'b1, 1'b1, w);
        end
        run_cycle(1'b1, 1'b0, 0);

        $display("loads checked: %0d", loads_checked);
        $display("TEST OK");
        $finish;
    end

    // reset, sweep, random cycles and a margin for the final flush
    initial begin
        #((`RAM_WORDS + NUM_CYCLES + 100) * CLK_PERIOD);
        $display("ERROR: watchdog timeout, the run did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/mem_isa_pkg.sv
design/lsq_pkg.sv
design/mem_op_decode.sv
design/store_queue.sv
design/data_ram.sv
design/load_result_merge.sv
design/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory back end testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module mem_subsystem_tb \
    -o mem_subsystem_sim &&
./obj_dir/mem_subsystem_sim &&
echo "simulation exited cleanly" ||
{ echo "simulation build or run failed"; exit 1; }
